/* verilog/sdramPkg.sv */
package sdramPkg;

    localparam int addrWidth = 21;
    localparam int dataWidth = 32;
    localparam int byteEnWidth = 4;
    localparam int rowWidth = 11;
    localparam int bankWidth = 2;
    localparam int colWidth = 8;
    localparam int numBanks = 2 ** bankWidth;

    typedef logic [addrWidth-1:0] addrT;      // Bank, then row, then column.
    typedef logic [dataWidth-1:0] dataT;
    typedef logic [byteEnWidth-1:0] byteEnT;
    typedef logic [rowWidth-1:0] rowT;
    typedef logic [bankWidth-1:0] bankT;
    typedef logic [colWidth-1:0] colT;

    // Encoded as {ras, cas, we}, all active low.
    typedef enum logic [2:0] {
        cmdLoadMode  = 3'b000,
        cmdRefresh   = 3'b001,
        cmdPrecharge = 3'b010,
        cmdActive    = 3'b011,
        cmdWrite     = 3'b100,
        cmdRead      = 3'b101,
        cmdNop       = 3'b111
    } cmdT;

    localparam int casLatency = 2;
    localparam int tRcd = 2;
    localparam int tRp = 2;
    localparam int tRfc = 7;
    localparam int tMrd = 2;
    localparam int initWaitCycles = 100;         // Shortened power-up wait.
    localparam int refreshInterval = 300;        // Shortened refresh period.
    localparam int readLatency = 2 + tRcd + casLatency; // ACTIVE, tRcd, READ, CAS latency.

    localparam int allBanksBit = 10;             // Address bit that makes PRECHARGE hit every bank.
    localparam int modeCasLsb = 4;               // CAS latency field of the mode register.
    localparam rowT modeRegValue = rowT'(casLatency << modeCasLsb); // Burst length 1, sequential.

    localparam int initCntWidth = $clog2(initWaitCycles + 1);
    localparam int waitCntWidth = $clog2(tRfc + 1); // tRfc is the longest command gap.
    localparam int refreshCntWidth = $clog2(refreshInterval);

    typedef logic [initCntWidth-1:0] initCntT;
    typedef logic [waitCntWidth-1:0] waitCntT;
    typedef logic [refreshCntWidth-1:0] refreshCntT;

    typedef enum logic [2:0] {
        initPowerUp,
        initRefreshFirst,
        initRefreshSecond,
        initModeLoad,
        initSettle,
        initReady
    } initStateT;

    typedef enum logic [2:0] {
        ctrlIdle,
        ctrlRcdWait,
        ctrlClose,
        ctrlRpWait,
        ctrlRfcWait
    } ctrlStateT;

endpackage

/* verilog/sdramInit.sv */
module sdramInit (
    input  logic             clkSdr,
    input  logic             reset,
    output sdramPkg::cmdT    initCmd,
    output sdramPkg::rowT    initAddr,
    output sdramPkg::bankT   initBank,
    output logic             initDone
);

    sdramPkg::initStateT state;
    sdramPkg::initCntT   count;

    // Each state issues its command once the gap counter has run out.
    // The counter is loaded with the command gap minus one, so the next command
    // lands exactly that many cycles later on the SDRAM pins.
    always_ff @(posedge clkSdr) begin
        if (reset) begin
            state    <= sdramPkg::initPowerUp;
            count    <= sdramPkg::initCntT'(sdramPkg::initWaitCycles);
            initCmd  <= sdramPkg::cmdNop;
            initAddr <= '0;
            initBank <= '0;
            initDone <= 1'b0;
        end else begin
            initCmd <= sdramPkg::cmdNop;                  // Commands last one cycle.
            if (count != '0) begin
                count <= count - 1'b1;
            end else begin
                case (state)
                    sdramPkg::initPowerUp: begin
                        initCmd  <= sdramPkg::cmdPrecharge;
                        initAddr <= sdramPkg::rowT'(1 << sdramPkg::allBanksBit); // All banks.
                        count    <= sdramPkg::initCntT'(sdramPkg::tRp - 1);
                        state    <= sdramPkg::initRefreshFirst;
                    end
                    sdramPkg::initRefreshFirst: begin
                        initCmd <= sdramPkg::cmdRefresh;
                        count   <= sdramPkg::initCntT'(sdramPkg::tRfc - 1);
                        state   <= sdramPkg::initRefreshSecond;
                    end
                    sdramPkg::initRefreshSecond: begin
                        initCmd <= sdramPkg::cmdRefresh;
                        count   <= sdramPkg::initCntT'(sdramPkg::tRfc - 1);
                        state   <= sdramPkg::initModeLoad;
                    end
                    sdramPkg::initModeLoad: begin
                        initCmd  <= sdramPkg::cmdLoadMode;
                        initAddr <= sdramPkg::modeRegValue;
                        initBank <= '0;
                        count    <= sdramPkg::initCntT'(sdramPkg::tMrd); // One spare cycle for the handover.
                        state    <= sdramPkg::initSettle;
                    end
                    sdramPkg::initSettle: begin
                        initDone <= 1'b1;                 // Stays set until the next reset.
                        state    <= sdramPkg::initReady;
                    end
                    default: begin
                        state <= sdramPkg::initReady;
                    end
                endcase
            end
        end
    end

endmodule

/* verilog/sdramController.sv */
module sdramController (
    input  logic               clkSdr,
    input  logic               reset,
    input  logic               initDone,
    input  sdramPkg::cmdT      initCmd,
    input  sdramPkg::rowT      initAddr,
    input  sdramPkg::bankT     initBank,
    input  sdramPkg::addrT     addrIn,
    input  sdramPkg::addrT     addrOut,
    input  sdramPkg::byteEnT   byteEnable,
    input  sdramPkg::dataT     dataIn,
    input  logic               readEnable,
    input  sdramPkg::dataT     dqRead,
    output logic               ras,
    output logic               cas,
    output logic               we,
    output sdramPkg::bankT     bank,
    output sdramPkg::rowT      addr,
    output sdramPkg::dataT     dqWrite,
    output sdramPkg::byteEnT   dqMask,
    output logic               dqOutEnable,
    output sdramPkg::dataT     dataOut,
    output logic               readValid,
    output logic               busy
);

    sdramPkg::ctrlStateT  state;
    sdramPkg::waitCntT    waitCnt;
    sdramPkg::refreshCntT refreshCnt;
    logic                 refreshPending;
    logic                 refreshIssue;
    sdramPkg::cmdT        ctrlCmd;
    sdramPkg::cmdT        pinCmd;
    sdramPkg::bankT       ctrlBank;
    sdramPkg::rowT        ctrlAddr;
    logic                 writeReq;
    logic                 accept;
    logic                 readIssue;
    sdramPkg::addrT       reqAddr;
    sdramPkg::colT        reqCol;
    sdramPkg::dataT       reqData;
    sdramPkg::byteEnT     reqMask;
    logic                 reqWrite;
    logic [sdramPkg::casLatency-1:0] readPipe;

    assign writeReq = byteEnable != '0;                   // A write wins over a read.
    assign busy     = !initDone || state != sdramPkg::ctrlIdle || refreshPending;
    assign accept   = !busy && (writeReq || readEnable);
    assign reqAddr  = writeReq ? addrIn : addrOut;
    assign refreshIssue = state == sdramPkg::ctrlIdle && refreshPending;

    // The init sequencer owns the pins until it reports done.
    assign pinCmd      = initDone ? ctrlCmd : initCmd;
    assign {ras, cas, we} = pinCmd;
    assign bank        = initDone ? ctrlBank : initBank;
    assign addr        = initDone ? ctrlAddr : initAddr;
    assign dqWrite     = reqData;
    assign dqMask      = reqMask;
    assign readIssue   = pinCmd == sdramPkg::cmdRead;

    always_ff @(posedge clkSdr) begin
        if (reset) begin
            refreshCnt     <= sdramPkg::refreshCntT'(sdramPkg::refreshInterval - 1);
            refreshPending <= 1'b0;
        end else begin
            if (initDone) begin
                if (refreshCnt == '0) begin
                    refreshCnt <= sdramPkg::refreshCntT'(sdramPkg::refreshInterval - 1);
                end else begin
                    refreshCnt <= refreshCnt - 1'b1;
                end
            end
            if (initDone && refreshCnt == '0) begin
                refreshPending <= 1'b1;                   // Served once the current access closes.
            end else if (refreshIssue) begin
                refreshPending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clkSdr) begin
        if (accept) begin
            reqCol   <= reqAddr[sdramPkg::colWidth-1:0];
            reqData  <= dataIn;
            reqMask  <= ~byteEnable;                      // The SDRAM masks are active high.
            reqWrite <= writeReq;
        end
    end

    always_ff @(posedge clkSdr) begin
        if (reset) begin
            state       <= sdramPkg::ctrlIdle;
            waitCnt     <= '0;
            ctrlCmd     <= sdramPkg::cmdNop;
            ctrlBank    <= '0;
            ctrlAddr    <= '0;
            dqOutEnable <= 1'b0;
        end else begin
            ctrlCmd     <= sdramPkg::cmdNop;
            dqOutEnable <= 1'b0;
            case (state)
                sdramPkg::ctrlIdle: begin
                    if (refreshIssue) begin
                        ctrlCmd <= sdramPkg::cmdRefresh;
                        waitCnt <= sdramPkg::waitCntT'(sdramPkg::tRfc - 1);
                        state   <= sdramPkg::ctrlRfcWait;
                    end else if (accept) begin
                        ctrlCmd  <= sdramPkg::cmdActive;
                        ctrlBank <= reqAddr[sdramPkg::addrWidth-1 -: sdramPkg::bankWidth];
                        ctrlAddr <= reqAddr[sdramPkg::colWidth +: sdramPkg::rowWidth];
                        waitCnt  <= sdramPkg::waitCntT'(sdramPkg::tRcd - 1);
                        state    <= sdramPkg::ctrlRcdWait;
                    end
                end
                sdramPkg::ctrlRcdWait: begin
                    if (waitCnt != '0) begin
                        waitCnt <= waitCnt - 1'b1;
                    end else begin
                        ctrlCmd     <= reqWrite ? sdramPkg::cmdWrite : sdramPkg::cmdRead;
                        ctrlAddr    <= sdramPkg::rowT'(reqCol); // Bit 10 low, no auto precharge.
                        dqOutEnable <= reqWrite;
                        state       <= sdramPkg::ctrlClose;
                    end
                end
                sdramPkg::ctrlClose: begin
                    ctrlCmd  <= sdramPkg::cmdPrecharge;
                    ctrlAddr <= '0;                       // Only the open bank.
                    waitCnt  <= sdramPkg::waitCntT'(sdramPkg::tRp - 1);
                    state    <= sdramPkg::ctrlRpWait;
                end
                sdramPkg::ctrlRpWait,
                sdramPkg::ctrlRfcWait: begin
                    if (waitCnt != '0) begin
                        waitCnt <= waitCnt - 1'b1;
                    end else begin
                        state <= sdramPkg::ctrlIdle;
                    end
                end
                default: begin
                    state <= sdramPkg::ctrlIdle;
                end
            endcase
        end
    end

    // readValid is high in the readLatency-th cycle after the accepting edge.
    always_ff @(posedge clkSdr) begin
        if (reset) begin
            readPipe  <= '0;
            readValid <= 1'b0;
        end else begin
            readPipe  <= {readPipe[sdramPkg::casLatency-2:0], readIssue};
            readValid <= readPipe[sdramPkg::casLatency-1];
        end
    end

    always_ff @(posedge clkSdr) begin
        if (readPipe[sdramPkg::casLatency-1]) begin
            dataOut <= dqRead;                            // Word arrives casLatency after READ.
        end
    end

endmodule

/* verilog/sdramArray.sv */
module sdramArray (
    input  logic               clkSdr,
    input  logic               ras,
    input  logic               cas,
    input  logic               we,
    input  sdramPkg::bankT     bank,
    input  sdramPkg::rowT      addr,
    input  sdramPkg::dataT     dqWrite,
    input  sdramPkg::byteEnT   dqMask,
    input  logic               dqOutEnable,
    output sdramPkg::dataT     dqRead
);

    sdramPkg::dataT mem [2 ** sdramPkg::addrWidth];
    sdramPkg::rowT  openRow [sdramPkg::numBanks];
    logic [sdramPkg::numBanks-1:0] rowOpen;
    logic           modeLoaded;
    sdramPkg::dataT readDelay [sdramPkg::casLatency];
    sdramPkg::cmdT  cmd;
    sdramPkg::addrT wordAddr;
    logic           bankReady;

    assign cmd       = sdramPkg::cmdT'({ras, cas, we});
    assign wordAddr  = {bank, openRow[bank], addr[sdramPkg::colWidth-1:0]};
    assign bankReady = rowOpen[bank] && modeLoaded;       // Accesses need an open row.
    assign dqRead    = readDelay[sdramPkg::casLatency-1];

    always_ff @(posedge clkSdr) begin
        case (cmd)
            sdramPkg::cmdActive: begin
                if (!rowOpen[bank]) begin                 // ACTIVE on an open bank is dropped.
                    openRow[bank] <= addr;
                    rowOpen[bank] <= 1'b1;
                end
            end
            sdramPkg::cmdPrecharge: begin
                if (addr[sdramPkg::allBanksBit]) begin
                    rowOpen <= '0;
                end else begin
                    rowOpen[bank] <= 1'b0;
                end
            end
            sdramPkg::cmdLoadMode: begin
                // The model only runs at its own CAS latency.
                modeLoaded <= addr[sdramPkg::modeCasLsb +: 3] == 3'(sdramPkg::casLatency);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clkSdr) begin
        if (cmd == sdramPkg::cmdWrite && bankReady && dqOutEnable) begin
            for (int i = 0; i < sdramPkg::byteEnWidth; i++) begin
                if (!dqMask[i]) begin
                    mem[wordAddr][8*i +: 8] <= dqWrite[8*i +: 8]; // Masked bytes keep old data.
                end
            end
        end
    end

    always_ff @(posedge clkSdr) begin
        if (cmd == sdramPkg::cmdRead && bankReady) begin
            readDelay[0] <= mem[wordAddr];
        end else begin
            readDelay[0] <= '0;                           // Idle bus reads as zero.
        end
        for (int i = 1; i < sdramPkg::casLatency; i++) begin
            readDelay[i] <= readDelay[i-1];
        end
    end

endmodule

/* verilog/sdramMemory.sv */
module sdramMemory (
    input  logic               clkSdr,
    input  logic               reset,
    input  sdramPkg::addrT     addrIn,
    input  sdramPkg::addrT     addrOut,
    input  sdramPkg::byteEnT   byteEnable,
    input  sdramPkg::dataT     dataIn,
    input  logic               readEnable,
    output sdramPkg::dataT     dataOut,
    output logic               readValid,
    output logic               busy,
    output logic               initDone
);

    sdramPkg::cmdT    initCmd;
    sdramPkg::rowT    initAddr;
    sdramPkg::bankT   initBank;
    logic             sdrRas;
    logic             sdrCas;
    logic             sdrWe;
    sdramPkg::bankT   sdrBank;
    sdramPkg::rowT    sdrAddr;
    sdramPkg::dataT   sdrDqWrite;
    sdramPkg::dataT   sdrDqRead;
    sdramPkg::byteEnT sdrDqMask;
    logic             sdrDqOutEnable;

    sdramInit uInit (
        .clkSdr   (clkSdr),
        .reset    (reset),
        .initCmd  (initCmd),
        .initAddr (initAddr),
        .initBank (initBank),
        .initDone (initDone)
    );

    sdramController uController (
        .clkSdr      (clkSdr),
        .reset       (reset),
        .initDone    (initDone),
        .initCmd     (initCmd),
        .initAddr    (initAddr),
        .initBank    (initBank),
        .addrIn      (addrIn),
        .addrOut     (addrOut),
        .byteEnable  (byteEnable),
        .dataIn      (dataIn),
        .readEnable  (readEnable),
        .dqRead      (sdrDqRead),
        .ras         (sdrRas),
        .cas         (sdrCas),
        .we          (sdrWe),
        .bank        (sdrBank),
        .addr        (sdrAddr),
        .dqWrite     (sdrDqWrite),
        .dqMask      (sdrDqMask),
        .dqOutEnable (sdrDqOutEnable),
        .dataOut     (dataOut),
        .readValid   (readValid),
        .busy        (busy)
    );

    sdramArray uArray (
        .clkSdr      (clkSdr),
        .ras         (sdrRas),
        .cas         (sdrCas),
        .we          (sdrWe),
        .bank        (sdrBank),
        .addr        (sdrAddr),
        .dqWrite     (sdrDqWrite),
        .dqMask      (sdrDqMask),
        .dqOutEnable (sdrDqOutEnable),
        .dqRead      (sdrDqRead)
    );

endmodule

/* testbench/sdramTb.sv */
module sdramTb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {
        opWrite,
        opRead,
        opIdle
    } opT;

    typedef struct packed {
        opT               op;
        sdramPkg::addrT   addr;
        sdramPkg::dataT   data;
        sdramPkg::byteEnT byteEn;
        logic [15:0]      waitCycles;
    } entryT;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 4;
    localparam int initCycles = sdramPkg::initWaitCycles + sdramPkg::tRp
        + 2 * sdramPkg::tRfc + sdramPkg::tMrd + 2;
    localparam int maxBusyCycles = sdramPkg::readLatency + 2 * sdramPkg::tRfc + 20;
    localparam int idleCycles = sdramPkg::refreshInterval + 40; // Long enough to see a refresh.

    logic             clkSdr = 1'b0;
    logic             reset;
    sdramPkg::addrT   addrIn;
    sdramPkg::addrT   addrOut;
    sdramPkg::byteEnT byteEnable;
    sdramPkg::dataT   dataIn;
    logic             readEnable;
    sdramPkg::dataT   dataOut;
    logic             readValid;
    logic             busy;
    logic             initDone;

    entryT          entries [$];
    sdramPkg::dataT shadow [sdramPkg::addrT];             // Expected contents, by word address.
    int             errors = 0;
    int             testsFailed = 0;

    sdramMemory sdramMemory_inst (
        .clkSdr     (clkSdr),
        .reset      (reset),
        .addrIn     (addrIn),
        .addrOut    (addrOut),
        .byteEnable (byteEnable),
        .dataIn     (dataIn),
        .readEnable (readEnable),
        .dataOut    (dataOut),
        .readValid  (readValid),
        .busy       (busy),
        .initDone   (initDone)
    );

    always #(clkPeriod / 2) clkSdr = ~clkSdr;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    function automatic sdramPkg::addrT makeAddr(input sdramPkg::bankT b, input sdramPkg::rowT r,
                                                input sdramPkg::colT c);
        return {b, r, c};
    endfunction

    // Enabled bytes take the new data, the rest keep the old word.
    function automatic sdramPkg::dataT mergeBytes(input sdramPkg::dataT oldWord,
                                                  input sdramPkg::dataT newWord,
                                                  input sdramPkg::byteEnT be);
        sdramPkg::dataT result;
        result = oldWord;
        for (int i = 0; i < sdramPkg::byteEnWidth; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic addEntry(input opT op, input sdramPkg::addrT a, input sdramPkg::dataT d,
                            input sdramPkg::byteEnT be, input int waitCycles);
        entryT entry;
        entry.op         = op;
        entry.addr       = a;
        entry.data       = d;
        entry.byteEn     = be;
        entry.waitCycles = 16'(waitCycles);
        entries.push_back(entry);
    endtask

    task automatic buildTable();
        sdramPkg::addrT wordA;
        sdramPkg::addrT wordB;
        sdramPkg::addrT sameCol [5];
        wordA      = makeAddr(2'd0, 11'h003, 8'h20);
        wordB      = makeAddr(2'd1, 11'h155, 8'h41);
        sameCol[0] = makeAddr(2'd0, 11'h005, 8'h10);
        sameCol[1] = makeAddr(2'd1, 11'h005, 8'h10);
        sameCol[2] = makeAddr(2'd2, 11'h7ff, 8'h10);
        sameCol[3] = makeAddr(2'd3, 11'h000, 8'h10);
        sameCol[4] = makeAddr(2'd0, 11'h006, 8'h10);     // Bank 0 again, other row.
        addEntry(opWrite, wordA, 32'h1234_5678, 4'hf, 0);
        addEntry(opRead, wordA, '0, '0, 0);
        addEntry(opWrite, wordB, $urandom(), 4'hf, 0);
        addEntry(opRead, wordB, '0, '0, 0);
        addEntry(opWrite, wordB, $urandom(), 4'b0001, 0);
        addEntry(opRead, wordB, '0, '0, 0);
        addEntry(opWrite, wordB, 32'haabb_ccdd, 4'b0100, 0);
        addEntry(opRead, wordB, '0, '0, 0);
        addEntry(opWrite, wordB, $urandom(), 4'b1100, 0);
        addEntry(opRead, wordB, '0, '0, 0);
        addEntry(opWrite, wordA, 32'h0000_beef, 4'b0011, 0);
        addEntry(opRead, wordA, '0, '0, 0);
        foreach (sameCol[i]) begin
            addEntry(opWrite, sameCol[i], $urandom(), 4'hf, 0);
        end
        foreach (sameCol[i]) begin
            addEntry(opRead, sameCol[i], '0, '0, 0);
        end
        addEntry(opIdle, '0, '0, '0, idleCycles);
        addEntry(opRead, wordA, '0, '0, 0);
        addEntry(opRead, wordB, '0, '0, 0);
        addEntry(opRead, sameCol[2], '0, '0, 0);
        addEntry(opWrite, makeAddr(2'd3, 11'h400, 8'hff), $urandom(), 4'hf, 0);
        addEntry(opRead, makeAddr(2'd3, 11'h400, 8'hff), '0, '0, 0);
    endtask

    task automatic waitNotBusy();
        int waited;
        waited = 0;
        while (busy && waited < maxBusyCycles) begin
            @(negedge clkSdr);
            waited++;
        end
        if (busy) begin
            $display("ERROR at %0d ns: busy stayed high for %0d cycles", $time, waited);
            errors++;
        end
    endtask

    task automatic writeWord(input sdramPkg::addrT a, input sdramPkg::dataT d,
                             input sdramPkg::byteEnT be);
        sdramPkg::dataT oldWord;
        oldWord = shadow.exists(a) ? shadow[a] : '0;
        waitNotBusy();
        addrIn     = a;
        dataIn     = d;
        byteEnable = be;
        @(posedge clkSdr);                                // Accepting edge.
        @(negedge clkSdr);
        byteEnable = '0;
        checkValue("busy", 32'(busy), 32'd1);
        shadow[a] = mergeBytes(oldWord, d, be);
    endtask

    task automatic readWord(input sdramPkg::addrT a);
        sdramPkg::dataT expected;
        int             latency;
        if (!shadow.exists(a)) begin
            $display("ERROR at %0d ns: the table reads address %h before writing it", $time, a);
            errors++;
        end
        expected = shadow.exists(a) ? shadow[a] : '0;
        waitNotBusy();
        addrOut    = a;
        readEnable = 1'b1;
        @(posedge clkSdr);
        @(negedge clkSdr);
        readEnable = 1'b0;
        checkValue("busy", 32'(busy), 32'd1);
        latency = 1;                                      // Cycles counted from the accepting edge.
        while (!readValid && latency <= sdramPkg::readLatency + 20) begin
            @(negedge clkSdr);
            latency++;
        end
        if (!readValid) begin
            $display("ERROR at %0d ns: no readValid pulse for the read of %h", $time, a);
            errors++;
        end else begin
            checkValue("readValid latency", 32'(latency), 32'(sdramPkg::readLatency));
            checkValue("dataOut", dataOut, expected);
            @(negedge clkSdr);
            checkValue("readValid", 32'(readValid), 32'd0); // A pulse lasts one cycle.
        end
    endtask

    task automatic idleWait(input int cycles);
        logic sawBusy;
        sawBusy = 1'b0;
        repeat (cycles) begin
            @(negedge clkSdr);
            sawBusy |= busy;
        end
        if (cycles > sdramPkg::refreshInterval) begin
            checkValue("busy", 32'(sawBusy), 32'd1);       // Only a refresh can raise it here.
        end
    endtask

    task automatic checkInit();
        int cycles;
        cycles = 0;
        while (!initDone && cycles < initCycles + 20) begin
            @(posedge clkSdr);
            @(negedge clkSdr);
            cycles++;
            checkValue("readValid", 32'(readValid), 32'd0);
            if (!initDone) begin
                checkValue("busy", 32'(busy), 32'd1);
            end
        end
        checkValue("initDone cycle", 32'(cycles), 32'(initCycles));
    endtask

    task automatic reportTest(input int index, input string what, input int errorsBefore);
        if (errors == errorsBefore) begin
            $display("test %0d %s: ok", index, what);
        end else begin
            $display("test %0d %s: mismatch", index, what);
            testsFailed++;
        end
    endtask

    initial begin
        int errorsBefore;
        void'($urandom(32'h7449));
        reset      = 1'b1;
        addrIn     = '0;
        addrOut    = '0;
        byteEnable = '0;
        dataIn     = '0;
        readEnable = 1'b0;
        buildTable();
        repeat (resetCycles) @(posedge clkSdr);
        @(negedge clkSdr);
        reset = 1'b0;
        checkInit();
        reportTest(0, "initialization", 0);
        for (int i = 0; i < entries.size(); i++) begin
            errorsBefore = errors;
            case (entries[i].op)
                opWrite: writeWord(entries[i].addr, entries[i].data, entries[i].byteEn);
                opRead:  readWord(entries[i].addr);
                default: idleWait(int'(entries[i].waitCycles));
            endcase
            reportTest(i + 1, $sformatf("%s %h be %b", entries[i].op.name(), entries[i].addr,
                                        entries[i].byteEn), errorsBefore);
        end
        $display("Summary: %0d tests, %0d failed, %0d errors", entries.size() + 1,
                 testsFailed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        longint limitNs;
        #1;                                               // The table is built at time zero.
        limitNs = longint'(entries.size())
            * (sdramPkg::readLatency + sdramPkg::refreshInterval + 20) * clkPeriod
            + (resetCycles + initCycles + 20) * clkPeriod;
        #(limitNs);
        $display("Timeout: the tests did not finish within %0d ns", limitNs);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* all.f */
verilog/sdramPkg.sv
verilog/sdramInit.sv
verilog/sdramController.sv
verilog/sdramArray.sv
verilog/sdramMemory.sv
testbench/sdramTb.sv

/* Makefile */
# Verilator build and run for the SDRAM memory block.

VERILATOR ?= verilator
TOP       ?= sdramTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= PASS: all tests

SIM_EXE := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so a crash without the pass line also fails.
run: $(SIM_EXE)
	$(SIM_EXE) | tee $(LOG)
	grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
